/* include/decode_tb_vectors.svh */
localparam int num_vec = 9;

localparam logic [6:0] fl_none = 7'h00;  // invalid slot, plain no-op
localparam logic [6:0] fl_ok   = 7'h01;
localparam logic [6:0] fl_ill  = 7'h02;
localparam logic [6:0] fl_halt = 7'h05;
localparam logic [6:0] fl_ubr  = 7'h09;
localparam logic [6:0] fl_cbr  = 7'h11;
localparam logic [6:0] fl_st   = 7'h21;
localparam logic [6:0] fl_ld   = 7'h41;

// columns: inst, npc, slot_valid, op_type, opa, opa_is_value, opb, opb_is_value,
// dest, alu_func, fu_sel, flags {rd_mem wr_mem cond uncond halt illegal valid_inst}
typedef struct {
	inst_t      inst;
	word_t      npc;
	logic       slot_valid;
	logic [5:0] op_type;
	word_t      opa;
	logic       opa_is_value;
	word_t      opb;
	logic       opb_is_value;
	reg_idx_t   dest;
	alu_func_e  alu;
	fu_sel_e    fu;
	logic [6:0] flags;
} slot_vec_t;

slot_vec_t vec_tab [num_vec][num_slots];

////////////////////////////////////////////////////////////
// instruction word builders
////////////////////////////////////////////////////////////
function automatic inst_t op_fmt(logic [5:0] op, reg_idx_t ra, reg_idx_t rb,
	logic [6:0] fn, reg_idx_t rc);
	return {op, ra, rb, 3'b000, 1'b0, fn, rc};  // operate, register b
endfunction

function automatic inst_t lit_fmt(logic [5:0] op, reg_idx_t ra, logic [7:0] lit,
	logic [6:0] fn, reg_idx_t rc);
	return {op, ra, lit, 1'b1, fn, rc};  // bit 12 marks the literal
endfunction

function automatic inst_t mem_fmt(logic [5:0] op, reg_idx_t ra, reg_idx_t rb,
	logic [15:0] disp);
	return {op, ra, rb, disp};
endfunction

function automatic inst_t br_fmt(logic [5:0] op, reg_idx_t ra, logic [20:0] disp);
	return {op, ra, disp};  // disp counts words
endfunction

////////////////////////////////////////////////////////////
// hand-decoded expectations
////////////////////////////////////////////////////////////
task automatic fill_table();
	// addq reg form, cmpult literal 200
	vec_tab[0][0] = '{op_fmt(6'h10, 5'd1, 5'd2, 7'h20, 5'd3), 64'h1004, 1'b1, 6'h10,
		64'd1, 1'b0, 64'd2, 1'b0, 5'd3, alu_addq, fu_adder, fl_ok};
	vec_tab[0][1] = '{lit_fmt(6'h10, 5'd4, 8'd200, 7'h1d, 5'd5), 64'h1008, 1'b1, 6'h10,
		64'd4, 1'b0, 64'd200, 1'b1, 5'd5, alu_cmpult, fu_adder, fl_ok};
	// and, sll by literal 63
	vec_tab[1][0] = '{op_fmt(6'h11, 5'd6, 5'd7, 7'h00, 5'd8), 64'h1104, 1'b1, 6'h11,
		64'd6, 1'b0, 64'd7, 1'b0, 5'd8, alu_and, fu_adder, fl_ok};
	vec_tab[1][1] = '{lit_fmt(6'h12, 5'd9, 8'd63, 7'h39, 5'd10), 64'h1108, 1'b1, 6'h12,
		64'd9, 1'b0, 64'd63, 1'b1, 5'd10, alu_sll, fu_adder, fl_ok};
	// mulq goes to the multiplier, lda is address only
	vec_tab[2][0] = '{op_fmt(6'h13, 5'd11, 5'd12, 7'h20, 5'd13), 64'h1204, 1'b1, 6'h13,
		64'd11, 1'b0, 64'd12, 1'b0, 5'd13, alu_mulq, fu_mult, fl_ok};
	vec_tab[2][1] = '{mem_fmt(6'h08, 5'd14, 5'd15, 16'h0100), 64'h1208, 1'b1, 6'h08,
		64'h100, 1'b1, 64'd15, 1'b0, 5'd14, alu_addq, fu_mem, fl_ok};
	// ldq with -8, stq writes no register
	vec_tab[3][0] = '{mem_fmt(6'h29, 5'd16, 5'd17, 16'hfff8), 64'h1304, 1'b1, 6'h29,
		64'hffff_ffff_ffff_fff8, 1'b1, 64'd17, 1'b0, 5'd16, alu_addq, fu_mem, fl_ld};
	vec_tab[3][1] = '{mem_fmt(6'h2d, 5'd18, 5'd19, 16'h0010), 64'h1308, 1'b1, 6'h2d,
		64'h10, 1'b1, 64'd19, 1'b0, zero_reg, alu_addq, fu_mem, fl_st};
	// br +5 words, bsr -2 words
	vec_tab[4][0] = '{br_fmt(6'h30, 5'd26, 21'd5), 64'h2004, 1'b1, 6'h30,
		64'h2004, 1'b1, 64'd20, 1'b1, 5'd26, alu_addq, fu_adder, fl_ubr};
	vec_tab[4][1] = '{br_fmt(6'h34, 5'd26, 21'h1ffffe), 64'h2008, 1'b1, 6'h34,
		64'h2008, 1'b1, 64'hffff_ffff_ffff_fff8, 1'b1, 5'd26, alu_addq, fu_adder, fl_ubr};
	// beq, jsr through r27
	vec_tab[5][0] = '{br_fmt(6'h39, 5'd1, 21'h10), 64'h3004, 1'b1, 6'h39,
		64'h3004, 1'b1, 64'h40, 1'b1, zero_reg, alu_addq, fu_adder, fl_cbr};
	vec_tab[5][1] = '{mem_fmt(6'h1a, 5'd26, 5'd27, 16'h4000), 64'h3008, 1'b1, 6'h1a,
		64'hffff_ffff_ffff_fffc, 1'b1, 64'd27, 1'b0, 5'd26, alu_and, fu_adder, fl_ubr};
	// halt, fbeq is illegal
	vec_tab[6][0] = '{32'h0000_0555, 64'h4004, 1'b1, 6'h00,
		64'd0, 1'b0, 64'd0, 1'b0, zero_reg, alu_addq, fu_adder, fl_halt};
	vec_tab[6][1] = '{br_fmt(6'h31, 5'd1, 21'd4), 64'h4008, 1'b1, 6'h31,
		64'd1, 1'b0, 64'd0, 1'b0, zero_reg, alu_addq, fu_adder, fl_ill};
	// unknown opcode 0x1c, then a slot with its valid bit low
	vec_tab[7][0] = '{op_fmt(6'h1c, 5'd2, 5'd3, 7'h00, 5'd4), 64'h5004, 1'b1, 6'h1c,
		64'd2, 1'b0, 64'd3, 1'b0, zero_reg, alu_addq, fu_adder, fl_ill};
	vec_tab[7][1] = '{op_fmt(6'h10, 5'd1, 5'd2, 7'h20, 5'd3), 64'h5008, 1'b0, 6'h10,
		64'd1, 1'b0, 64'd2, 1'b0, zero_reg, alu_addq, fu_adder, fl_none};
	// same op in both slots, fields must stay per slot
	vec_tab[8][0] = '{op_fmt(6'h11, 5'd1, 5'd2, 7'h20, 5'd3), 64'h6004, 1'b1, 6'h11,
		64'd1, 1'b0, 64'd2, 1'b0, 5'd3, alu_bis, fu_adder, fl_ok};
	vec_tab[8][1] = '{op_fmt(6'h11, 5'd4, 5'd5, 7'h20, 5'd6), 64'h6008, 1'b1, 6'h11,
		64'd4, 1'b0, 64'd5, 1'b0, 5'd6, alu_bis, fu_adder, fl_ok};
endtask

/* dv/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;
	import alpha_decode_pkg::*;

	localparam int num_slots = 2;

	logic      clock;
	logic      arst_n;
	logic      in_valid;
	logic      in_ready;
	inst_t     in_inst           [num_slots];
	word_t     in_npc            [num_slots];
	logic      in_slot_valid     [num_slots];
	logic      out_valid;
	logic      out_ready;
	word_t     out_opa           [num_slots];
	logic      out_opa_is_value  [num_slots];
	word_t     out_opb           [num_slots];
	logic      out_opb_is_value  [num_slots];
	reg_idx_t  out_dest_idx      [num_slots];
	alu_func_e out_alu_func      [num_slots];
	fu_sel_e   out_fu_sel        [num_slots];
	logic [5:0] out_op_type      [num_slots];
	logic      out_rd_mem        [num_slots];
	logic      out_wr_mem        [num_slots];
	logic      out_cond_branch   [num_slots];
	logic      out_uncond_branch [num_slots];
	logic      out_halt          [num_slots];
	logic      out_illegal       [num_slots];
	logic      out_valid_inst    [num_slots];

	`include "decode_tb_vectors.svh"

	localparam int bp_len   = 16 * num_vec;          // allowance for random stalls
	localparam int wd_limit = num_vec * 40 + bp_len;  // cycles

	int seed = 57;

	decode_top #(.num_slots(num_slots)) UUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;  // 20 ns
	end

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////
	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic drive_bundle(input int k);
		in_valid = 1'b1;
		for (int s = 0; s < num_slots; s++) begin
			in_inst[s]       = vec_tab[k][s].inst;
			in_npc[s]        = vec_tab[k][s].npc;
			in_slot_valid[s] = vec_tab[k][s].slot_valid;
		end
	endtask

	task automatic check_bundle(input int k);
		string tag;
		for (int s = 0; s < num_slots; s++) begin
			tag = $sformatf("entry %0d slot %0d", k, s);
			compare({tag, " opa"}, out_opa[s], vec_tab[k][s].opa);
			compare({tag, " opa_is_value"}, 64'(out_opa_is_value[s]),
				64'(vec_tab[k][s].opa_is_value));
			compare({tag, " opb"}, out_opb[s], vec_tab[k][s].opb);
			compare({tag, " opb_is_value"}, 64'(out_opb_is_value[s]),
				64'(vec_tab[k][s].opb_is_value));
			compare({tag, " dest_idx"}, 64'(out_dest_idx[s]), 64'(vec_tab[k][s].dest));
			compare({tag, " alu_func"}, 64'(out_alu_func[s]), 64'(vec_tab[k][s].alu));
			compare({tag, " fu_sel"}, 64'(out_fu_sel[s]), 64'(vec_tab[k][s].fu));
			compare({tag, " op_type"}, 64'(out_op_type[s]), 64'(vec_tab[k][s].op_type));
			compare({tag, " flags"}, 64'({out_rd_mem[s], out_wr_mem[s], out_cond_branch[s],
				out_uncond_branch[s], out_halt[s], out_illegal[s], out_valid_inst[s]}),
				64'(vec_tab[k][s].flags));
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and response, all on the falling edge
	////////////////////////////////////////////////////////////
	initial begin
		int tx_idx;
		int rx_idx;
		int cycle;
		int rnd;
		int stalls;
		bit in_fire;
		bit out_fire;
		int accept_q[$];  // cycle of each accepted bundle

		fill_table();
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		for (int s = 0; s < num_slots; s++) begin
			in_inst[s]       = '0;
			in_npc[s]        = '0;
			in_slot_valid[s] = 1'b0;
		end
		repeat (5) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		#1;
		compare("in_ready after reset", 64'(in_ready), 64'd1);
		compare("out_valid after reset", 64'(out_valid), 64'd0);

		tx_idx = 0;
		rx_idx = 0;
		cycle  = 0;
		stalls = 0;
		// table goes through twice, second pass under random out_ready
		while (rx_idx < 2 * num_vec) begin
			@(negedge clock);
			cycle++;
			rnd       = $random(seed);
			out_ready = (rx_idx < num_vec) ? 1'b1 : rnd[0];
			if (tx_idx < 2 * num_vec)
				drive_bundle(tx_idx % num_vec);  // held until taken
			else
				in_valid = 1'b0;
			#1;  // combinational readies settle
			in_fire  = in_valid && in_ready;
			out_fire = out_valid && out_ready;
			if (out_valid)
				check_bundle(rx_idx % num_vec);  // every stalled cycle too
			if (out_valid && !out_ready)
				stalls++;
			if (out_fire) begin
				compare("bundle in flight", 64'(accept_q.size() != 0), 64'd1);
				if (rx_idx < num_vec)
					compare("accept to output cycles", 64'(cycle - accept_q[0]), 64'd2);
				void'(accept_q.pop_front());
				rx_idx++;
			end
			if (in_fire) begin
				accept_q.push_back(cycle);
				tx_idx++;
			end
		end

		compare("stall cycles seen", 64'(stalls > 0), 64'd1);
		repeat (3) @(negedge clock);
		#1;
		compare("out_valid after drain", 64'(out_valid), 64'd0);  // nothing duplicated

		$display("Done: no errors");
		$finish;
	end

	initial begin
		repeat (wd_limit) @(posedge clock);
		$display("watchdog: bundles still missing after %0d cycles", wd_limit);
		$display("Done: errors found");
		$fatal(1);
	end

endmodule

/* rtl/alpha_decode_pkg.sv */
package alpha_decode_pkg;

	////////////////////////////////////////////////////////////
	// basic datapath types
	////////////////////////////////////////////////////////////
	typedef logic [63:0] word_t;  // one datapath word
	typedef logic [31:0] inst_t;  // one instruction word
	typedef logic [4:0]  reg_idx_t;

	localparam reg_idx_t zero_reg = 5'd31;  // r31 reads zero, writes vanish

	////////////////////////////////////////////////////////////
	// mux selects and unit choice
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		opa_is_rega,
		opa_is_mem_disp,
		opa_is_npc,
		opa_is_not3       // ~3, word-aligns a jump target
	} opa_sel_e;

	typedef enum logic [1:0] {
		opb_is_regb,
		opb_is_alu_imm,   // 8-bit literal
		opb_is_br_disp
	} opb_sel_e;

	typedef enum logic [1:0] {
		dest_is_regc,
		dest_is_rega,
		dest_none
	} dest_sel_e;

	typedef enum logic [4:0] {
		alu_addq, alu_subq, alu_and, alu_bic,
		alu_bis, alu_ornot, alu_xor, alu_eqv,
		alu_srl, alu_sll, alu_sra, alu_mulq,
		alu_cmpeq, alu_cmplt, alu_cmple, alu_cmpult,
		alu_cmpule
	} alu_func_e;

	typedef enum logic [1:0] {
		fu_adder,
		fu_mult,
		fu_mem
	} fu_sel_e;

	////////////////////////////////////////////////////////////
	// major opcodes, inst[31:26]
	////////////////////////////////////////////////////////////
	localparam logic [5:0] op_pal      = 6'h00;
	localparam logic [5:0] op_lda      = 6'h08;
	localparam logic [5:0] op_inta_grp = 6'h10;  // integer arithmetic
	localparam logic [5:0] op_intl_grp = 6'h11;  // logical
	localparam logic [5:0] op_ints_grp = 6'h12;  // shifts
	localparam logic [5:0] op_intm_grp = 6'h13;  // multiply
	localparam logic [5:0] op_jsr_grp  = 6'h1a;  // jmp/jsr/ret/jsr_co
	localparam logic [5:0] op_ldq      = 6'h29;
	localparam logic [5:0] op_stq      = 6'h2d;
	localparam logic [5:0] op_br       = 6'h30;
	localparam logic [5:0] op_fbeq     = 6'h31;
	localparam logic [5:0] op_fblt     = 6'h32;
	localparam logic [5:0] op_fble     = 6'h33;
	localparam logic [5:0] op_bsr      = 6'h34;
	localparam logic [5:0] op_fbne     = 6'h35;
	localparam logic [5:0] op_fbge     = 6'h36;
	localparam logic [5:0] op_fbgt     = 6'h37;
	localparam logic [5:0] op_blbc     = 6'h38;
	localparam logic [5:0] op_beq      = 6'h39;
	localparam logic [5:0] op_blt      = 6'h3a;
	localparam logic [5:0] op_ble      = 6'h3b;
	localparam logic [5:0] op_blbs     = 6'h3c;
	localparam logic [5:0] op_bne      = 6'h3d;
	localparam logic [5:0] op_bge      = 6'h3e;
	localparam logic [5:0] op_bgt      = 6'h3f;

	localparam logic [25:0] pal_halt = 26'h0000555;

	////////////////////////////////////////////////////////////
	// function codes, inst[11:5]
	////////////////////////////////////////////////////////////
	localparam logic [6:0] fn_cmpult = 7'h1d;
	localparam logic [6:0] fn_addq   = 7'h20;
	localparam logic [6:0] fn_subq   = 7'h29;
	localparam logic [6:0] fn_cmpeq  = 7'h2d;
	localparam logic [6:0] fn_cmpule = 7'h3d;
	localparam logic [6:0] fn_cmplt  = 7'h4d;
	localparam logic [6:0] fn_cmple  = 7'h6d;
	localparam logic [6:0] fn_and    = 7'h00;
	localparam logic [6:0] fn_bic    = 7'h08;
	localparam logic [6:0] fn_bis    = 7'h20;
	localparam logic [6:0] fn_ornot  = 7'h28;
	localparam logic [6:0] fn_xor    = 7'h40;
	localparam logic [6:0] fn_eqv    = 7'h48;
	localparam logic [6:0] fn_srl    = 7'h34;
	localparam logic [6:0] fn_sll    = 7'h39;
	localparam logic [6:0] fn_sra    = 7'h3c;
	localparam logic [6:0] fn_mulq   = 7'h20;

	////////////////////////////////////////////////////////////
	// pipeline payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		inst_t inst;
		word_t npc;        // pc + 4 of this slot
		logic  slot_valid;
	} fetch_slot_t;

	typedef struct packed {
		word_t     opa;
		logic      opa_is_value;  // low means opa holds a register index
		word_t     opb;
		logic      opb_is_value;
		reg_idx_t  dest_idx;
		alu_func_e alu_func;
		fu_sel_e   fu_sel;
		logic [5:0] op_type;      // major opcode
		logic      rd_mem;
		logic      wr_mem;
		logic      cond_branch;
		logic      uncond_branch;
		logic      halt;
		logic      illegal;
		logic      valid_inst;
	} decoded_slot_t;

endpackage

/* rtl/decode_top.sv */
`timescale 1ns/1ps

module decode_top #(
	parameter int num_slots = 2
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  alpha_decode_pkg::inst_t     in_inst           [num_slots],
	input  alpha_decode_pkg::word_t     in_npc            [num_slots],
	input  logic                        in_slot_valid     [num_slots],
	output logic                        out_valid,
	input  logic                        out_ready,
	output alpha_decode_pkg::word_t     out_opa           [num_slots],
	output logic                        out_opa_is_value  [num_slots],
	output alpha_decode_pkg::word_t     out_opb           [num_slots],
	output logic                        out_opb_is_value  [num_slots],
	output alpha_decode_pkg::reg_idx_t  out_dest_idx      [num_slots],
	output alpha_decode_pkg::alu_func_e out_alu_func      [num_slots],
	output alpha_decode_pkg::fu_sel_e   out_fu_sel        [num_slots],
	output logic [5:0]                  out_op_type       [num_slots],
	output logic                        out_rd_mem        [num_slots],
	output logic                        out_wr_mem        [num_slots],
	output logic                        out_cond_branch   [num_slots],
	output logic                        out_uncond_branch [num_slots],
	output logic                        out_halt          [num_slots],
	output logic                        out_illegal       [num_slots],
	output logic                        out_valid_inst    [num_slots]
);
	import alpha_decode_pkg::*;

	typedef fetch_slot_t   [num_slots-1:0] fetch_bundle_t;
	typedef decoded_slot_t [num_slots-1:0] decoded_bundle_t;

	fetch_bundle_t   fetch_d;     // packed input bundle
	fetch_bundle_t   fetch_q;     // if/id contents
	decoded_bundle_t decoded_d;   // id_stage result
	decoded_bundle_t decoded_q;   // id/ex contents
	logic            if_id_valid;
	logic            id_ex_ready;

	for (genvar i = 0; i < num_slots; i++) begin : g_pack
		assign fetch_d[i] = '{inst: in_inst[i], npc: in_npc[i], slot_valid: in_slot_valid[i]};

		assign out_opa[i]           = decoded_q[i].opa;
		assign out_opa_is_value[i]  = decoded_q[i].opa_is_value;
		assign out_opb[i]           = decoded_q[i].opb;
		assign out_opb_is_value[i]  = decoded_q[i].opb_is_value;
		assign out_dest_idx[i]      = decoded_q[i].dest_idx;
		assign out_alu_func[i]      = decoded_q[i].alu_func;
		assign out_fu_sel[i]        = decoded_q[i].fu_sel;
		assign out_op_type[i]       = decoded_q[i].op_type;
		assign out_rd_mem[i]        = decoded_q[i].rd_mem;
		assign out_wr_mem[i]        = decoded_q[i].wr_mem;
		assign out_cond_branch[i]   = decoded_q[i].cond_branch;
		assign out_uncond_branch[i] = decoded_q[i].uncond_branch;
		assign out_halt[i]          = decoded_q[i].halt;
		assign out_illegal[i]       = decoded_q[i].illegal;
		assign out_valid_inst[i]    = decoded_q[i].valid_inst;
	end

	pipe_stage_reg #(.payload_t(fetch_bundle_t)) if_id_reg (
		.clock     (clock),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (fetch_d),
		.out_valid (if_id_valid),
		.out_ready (id_ex_ready),  // decode is combinational, ready passes through
		.out_data  (fetch_q)
	);

	id_stage #(.num_slots(num_slots)) u_id_stage (
		.clock    (clock),
		.arst_n   (arst_n),
		.slot_in  (fetch_q),
		.slot_out (decoded_d)
	);

	pipe_stage_reg #(.payload_t(decoded_bundle_t)) id_ex_reg (
		.clock     (clock),
		.arst_n    (arst_n),
		.in_valid  (if_id_valid),
		.in_ready  (id_ex_ready),
		.in_data   (decoded_d),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (decoded_q)
	);

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ps

module id_stage #(
	parameter int num_slots = 2
) (
	input  logic                                            clock,
	input  logic                                            arst_n,
	input  alpha_decode_pkg::fetch_slot_t   [num_slots-1:0] slot_in,
	output alpha_decode_pkg::decoded_slot_t [num_slots-1:0] slot_out
);
	import alpha_decode_pkg::*;

	for (genvar i = 0; i < num_slots; i++) begin : g_slot
		inst_t         inst;
		reg_idx_t      ra_idx;
		reg_idx_t      rb_idx;
		reg_idx_t      rc_idx;
		word_t         mem_disp;
		word_t         br_disp;
		word_t         alu_imm;
		opa_sel_e      opa_select;
		opb_sel_e      opb_select;
		dest_sel_e     dest_select;
		alu_func_e     alu_func;
		logic          rd_mem;
		logic          wr_mem;
		logic          cond_branch;
		logic          uncond_branch;
		logic          halt;
		logic          illegal;
		logic          valid_inst;
		decoded_slot_t dec;

		////////////////////////////////////////////////////////////
		// fields and immediates of this slot's own word
		////////////////////////////////////////////////////////////
		assign inst   = slot_in[i].inst;
		assign ra_idx = inst[25:21];
		assign rb_idx = inst[20:16];
		assign rc_idx = inst[4:0];

		assign mem_disp = {{48{inst[15]}}, inst[15:0]};          // sign-extended
		assign br_disp  = {{41{inst[20]}}, inst[20:0], 2'b00};   // word offset
		assign alu_imm  = {56'b0, inst[20:13]};                  // zero-extended

		inst_decoder u_dec (
			.inst          (inst),
			.inst_valid    (slot_in[i].slot_valid),
			.opa_select    (opa_select),
			.opb_select    (opb_select),
			.dest_select   (dest_select),
			.alu_func      (alu_func),
			.rd_mem        (rd_mem),
			.wr_mem        (wr_mem),
			.cond_branch   (cond_branch),
			.uncond_branch (uncond_branch),
			.halt          (halt),
			.illegal       (illegal),
			.valid_inst    (valid_inst)
		);

		////////////////////////////////////////////////////////////
		// operand, destination and unit muxes
		////////////////////////////////////////////////////////////
		always_comb begin
			// operand a
			case (opa_select)
				opa_is_mem_disp: begin
					dec.opa          = mem_disp;
					dec.opa_is_value = 1'b1;
				end
				opa_is_npc: begin
					dec.opa          = slot_in[i].npc;
					dec.opa_is_value = 1'b1;
				end
				opa_is_not3: begin
					dec.opa          = ~word_t'(3);  // clears low two bits
					dec.opa_is_value = 1'b1;
				end
				default: begin  // register a, resolved later
					dec.opa          = word_t'(ra_idx);
					dec.opa_is_value = 1'b0;
				end
			endcase

			// operand b
			case (opb_select)
				opb_is_alu_imm: begin
					dec.opb          = alu_imm;
					dec.opb_is_value = 1'b1;
				end
				opb_is_br_disp: begin
					dec.opb          = br_disp;
					dec.opb_is_value = 1'b1;
				end
				default: begin
					dec.opb          = word_t'(rb_idx);
					dec.opb_is_value = 1'b0;
				end
			endcase

			case (dest_select)
				dest_is_regc: dec.dest_idx = rc_idx;
				dest_is_rega: dec.dest_idx = ra_idx;
				default:      dec.dest_idx = zero_reg;  // nothing written
			endcase

			// memory groups 0x08, 0x20, 0x28 go to the load/store unit
			if (valid_inst && (inst[31:29] == 3'h1 || inst[31:29] == 3'h4 ||
				inst[31:29] == 3'h5))
				dec.fu_sel = fu_mem;
			else if (alu_func == alu_mulq)
				dec.fu_sel = fu_mult;
			else
				dec.fu_sel = fu_adder;

			dec.alu_func      = alu_func;
			dec.op_type       = inst[31:26];
			dec.rd_mem        = rd_mem;
			dec.wr_mem        = wr_mem;
			dec.cond_branch   = cond_branch;
			dec.uncond_branch = uncond_branch;
			dec.halt          = halt;
			dec.illegal       = illegal;
			dec.valid_inst    = valid_inst;
		end

		assign slot_out[i] = dec;

		// a slot never both loads and stores
		a_mem_excl: assert property (@(posedge clock) disable iff (!arst_n)
			!(slot_out[i].rd_mem && slot_out[i].wr_mem));
	end

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
	input  alpha_decode_pkg::inst_t     inst,
	input  logic                        inst_valid,   // low gives a no-op
	output alpha_decode_pkg::opa_sel_e  opa_select,
	output alpha_decode_pkg::opb_sel_e  opb_select,
	output alpha_decode_pkg::dest_sel_e dest_select,
	output alpha_decode_pkg::alu_func_e alu_func,
	output logic                        rd_mem,
	output logic                        wr_mem,
	output logic                        cond_branch,
	output logic                        uncond_branch,
	output logic                        halt,
	output logic                        illegal,
	output logic                        valid_inst
);
	import alpha_decode_pkg::*;

	logic [5:0] opcode;
	logic [6:0] func;

	assign opcode = inst[31:26];
	assign func   = inst[11:5];   // operate-format function field

	assign valid_inst = inst_valid && !illegal;  // halt still counts as valid

	always_comb begin
		// no-op: add r31 + r31 into nowhere
		opa_select    = opa_is_rega;
		opb_select    = opb_is_regb;
		dest_select   = dest_none;
		alu_func      = alu_addq;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;

		if (inst_valid) begin
			case (opcode[5:3])  // eight-opcode groups
				3'h0: begin
					// only the halt pal call is supported
					if (opcode == op_pal && inst[25:0] == pal_halt)
						halt = 1'b1;
					else
						illegal = 1'b1;
				end
				3'h2: begin  // integer operate, 0x10..0x17
					opb_select  = inst[12] ? opb_is_alu_imm : opb_is_regb;  // literal bit
					dest_select = dest_is_regc;
					case (opcode)
						op_inta_grp:
							case (func)
								fn_addq:   alu_func = alu_addq;
								fn_subq:   alu_func = alu_subq;
								fn_cmpeq:  alu_func = alu_cmpeq;
								fn_cmplt:  alu_func = alu_cmplt;
								fn_cmple:  alu_func = alu_cmple;
								fn_cmpult: alu_func = alu_cmpult;
								fn_cmpule: alu_func = alu_cmpule;
								default:   illegal = 1'b1;  // longword and scaled forms
							endcase
						op_intl_grp:
							case (func)
								fn_and:   alu_func = alu_and;
								fn_bic:   alu_func = alu_bic;
								fn_bis:   alu_func = alu_bis;
								fn_ornot: alu_func = alu_ornot;
								fn_xor:   alu_func = alu_xor;
								fn_eqv:   alu_func = alu_eqv;
								default:  illegal = 1'b1;  // cmov etc
							endcase
						op_ints_grp:
							case (func)
								fn_srl:  alu_func = alu_srl;
								fn_sll:  alu_func = alu_sll;
								fn_sra:  alu_func = alu_sra;
								default: illegal = 1'b1;  // byte manipulation
							endcase
						op_intm_grp:
							if (func == fn_mulq)
								alu_func = alu_mulq;
							else
								illegal = 1'b1;
						default: illegal = 1'b1;  // fp operate groups
					endcase
				end
				3'h3: begin
					if (opcode == op_jsr_grp) begin
						// target = rb & ~3, link into ra
						opa_select    = opa_is_not3;
						opb_select    = opb_is_regb;
						alu_func      = alu_and;
						dest_select   = dest_is_rega;
						uncond_branch = 1'b1;
					end else begin
						illegal = 1'b1;  // misc, fp moves
					end
				end
				3'h1, 3'h4, 3'h5: begin  // memory format
					opa_select  = opa_is_mem_disp;
					dest_select = dest_is_rega;
					case (opcode)
						op_lda: ;  // address only, no access
						op_ldq: rd_mem = 1'b1;
						op_stq: begin
							wr_mem      = 1'b1;
							dest_select = dest_none;  // ra is the store data
						end
						default: illegal = 1'b1;
					endcase
				end
				3'h6, 3'h7: begin  // branch format, target = npc + disp
					opa_select = opa_is_npc;
					opb_select = opb_is_br_disp;
					case (opcode)
						op_br, op_bsr: begin
							dest_select   = dest_is_rega;  // return address
							uncond_branch = 1'b1;
						end
						op_fbeq, op_fblt, op_fble, op_fbne, op_fbge, op_fbgt:
							illegal = 1'b1;
						op_blbc, op_beq, op_blt, op_ble, op_blbs, op_bne, op_bge, op_bgt:
							cond_branch = 1'b1;
						default: illegal = 1'b1;
					endcase
				end
			endcase
		end

		// illegal words carry no controls downstream
		if (illegal) begin
			opa_select    = opa_is_rega;
			opb_select    = opb_is_regb;
			dest_select   = dest_none;
			alu_func      = alu_addq;
			rd_mem        = 1'b0;
			wr_mem        = 1'b0;
			cond_branch   = 1'b0;
			uncond_branch = 1'b0;
		end
	end

endmodule

/* rtl/pipe_stage_reg.sv */
`timescale 1ns/1ps

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// open when empty or being drained this cycle
	assign in_ready = !valid_q || out_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;  // refill or go empty
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;  // capture on transfer only
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

	// stalled entry keeps its payload until taken
	a_hold_stable: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid && !out_ready |=> $stable(out_data));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the decode testbench with verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module decode_tb \
	-Mdir obj_dir -o decode_tb_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/decode_tb_sim > sim.log 2>&1 || echo "simulator returned nonzero"
cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* vlog.f */
+incdir+include
rtl/alpha_decode_pkg.sv
rtl/inst_decoder.sv
rtl/id_stage.sv
rtl/pipe_stage_reg.sv
rtl/decode_top.sv
dv/decode_tb.sv
